//--- filelist.f
+incdir+hdl
+incdir+tb
hdl/trigger_link_pkg.sv
hdl/cluster_capture.sv
hdl/link_startup.sv
hdl/link_framer.sv
hdl/link_serializer.sv
hdl/trigger_links.sv
tb/trigger_links_tb.sv

//--- tb/trigger_links_tests.svh
`ifndef TRIGGER_LINKS_TESTS_SVH
`define TRIGGER_LINKS_TESTS_SVH

// ------------------------------------------------------------
// Reset state and startup hold-off
// ------------------------------------------------------------
task automatic test_startup();
  int cycles;
  check_bit("startup tx_frame_start", 1'b0, tx_frame_start);
  check_bit("startup valid_clusters_or", 1'b0, valid_clusters_or);
  check_bit("startup link_ready", 1'b0, link_ready);
  check_mask("startup valid_clusters", '0, valid_clusters);
  check_links("startup idle", IDLE_WORD, IDLE_WORD);
  cycles = 0;
  while (!link_ready) begin
    if (cycles >= READY_TIMEOUT) begin
      $display("Timeout: link_ready did not rise after reset");
      abort_run();
    end
    bx_strobe = (cycles == 0 || cycles == 10);             // Too early, must be dropped
    clusters  = random_bx();
    @(negedge clk_80);
    cycles++;
    check_bit("startup early frame", 1'b0, tx_frame_start);
    check_links("startup early idle", IDLE_WORD, IDLE_WORD);
  end
  bx_strobe = 1'b0;
  check_count("startup length", `TRG_STARTUP_CYCLES, cycles);
  repeat (4) begin
    @(negedge clk_80);
    check_bit("startup dropped frame", 1'b0, tx_frame_start);
  end
endtask

task automatic test_valid_mask();
  trigger_link_pkg::cluster_bx_t c;
  string                         name;
  for (int n = 0; n < 8; n++) begin
    c = random_bx();
    for (int i = 0; i < `TRG_NUM_CLUSTERS; i++) begin
      if (n == 6) c[i].addr[10:9] = 2'b11;                 // Nothing valid
      if (n == 7) c[i].addr[10] = 1'b0;                    // All valid
    end
    name = $sformatf("valid_mask bx%0d", n);
    send_bx(c, 1'b0, 1'b0, 7'd1 + 7'(n));
    check_mask(name, mask_for(c), valid_clusters);
    check_bit({name, " or"}, |mask_for(c), valid_clusters_or);
    for (int i = 0; i < `TRG_NUM_CLUSTERS; i++) begin
      clusters[i].addr[10:9] = (c[i].addr[10:9] == 2'b11) ? 2'b00 : 2'b11;  // Inverted mask
    end
    repeat (4) @(negedge clk_80);                          // Frame drains
    check_mask({name, " hold"}, mask_for(c), valid_clusters);
  end
endtask

// Strobe, wait for the frame and check both words and the idle after it
task automatic check_frame(input string name, input trigger_link_pkg::cluster_bx_t c,
                           input logic bx0, input logic ovf, input logic [6:0] bxn,
                           input logic [7:0] marker);
  int          cycles;
  logic [55:0] pay_r;
  logic [55:0] pay_l;
  pay_r = half_payload(c, 1'b0);
  pay_l = half_payload(c, 1'b1);
  send_bx(c, bx0, ovf, bxn);
  cycles = 1;
  while (!tx_frame_start) begin
    if (cycles >= START_TIMEOUT) begin
      $display("Timeout: no frame start after the strobe in %s", name);
      abort_run();
    end
    check_links({name, " before frame"}, IDLE_WORD, IDLE_WORD);
    @(negedge clk_80);
    cycles++;
  end
  check_count({name, " latency"}, 3, cycles);
  check_links({name, " high"}, link_word(marker, pay_r, 0), link_word(marker, pay_l, 0));
  @(negedge clk_80);
  check_bit({name, " start pulse"}, 1'b0, tx_frame_start);
  check_links({name, " low"}, link_word(marker, pay_r, 1), link_word(marker, pay_l, 1));
  @(negedge clk_80);
  check_links({name, " idle after"}, IDLE_WORD, IDLE_WORD);
endtask

task automatic test_frames();
  logic [6:0] bxn;
  for (int n = 0; n < 6; n++) begin
    bxn = 7'($random(seed));
    check_frame($sformatf("frame bx%0d", n), random_bx(), 1'b0, 1'b0, bxn,
                marker_for(1'b0, 1'b0, bxn));
  end
endtask

task automatic test_marker_priority();
  check_frame("marker bc0 all set", random_bx(), 1'b1, 1'b1, 7'd0, `TRG_K28_0);
  check_frame("marker bc0 only", random_bx(), 1'b1, 1'b0, 7'd9, `TRG_K28_0);
  check_frame("marker ovf at bx 0", random_bx(), 1'b0, 1'b1, 7'd0, `TRG_K23_7);
  check_frame("marker ovf", random_bx(), 1'b0, 1'b1, 7'd33, `TRG_K23_7);
  check_frame("marker lat", random_bx(), 1'b0, 1'b0, 7'd0, `TRG_K28_7);
  check_frame("marker idle", random_bx(), 1'b0, 1'b0, 7'd100, `TRG_K28_5);
endtask

// Three strobes two cycles apart give six words with no gap
task automatic test_back_to_back();
  trigger_link_pkg::cluster_bx_t bx [3];
  logic [6:0]                    bxn [3];
  logic [7:0]                    mk [3];
  string                         name;
  int                            f;
  int                            ph;
  for (int n = 0; n < 3; n++) begin
    bx[n]  = random_bx();
    bxn[n] = 7'(n * 5);
    mk[n]  = marker_for(1'b0, n == 2, bxn[n]);
  end
  for (int cyc = 0; cyc < 10; cyc++) begin
    name = $sformatf("back_to_back cycle%0d", cyc);
    if (cyc >= 3 && cyc <= 8) begin
      f  = (cyc - 3) / 2;
      ph = (cyc - 3) % 2;
      check_bit({name, " start"}, ph == 0, tx_frame_start);
      check_links(name, link_word(mk[f], half_payload(bx[f], 1'b0), ph),
                  link_word(mk[f], half_payload(bx[f], 1'b1), ph));
    end else begin
      check_bit({name, " start"}, 1'b0, tx_frame_start);
      check_links(name, IDLE_WORD, IDLE_WORD);
    end
    bx_strobe = (cyc % 2 == 0 && cyc <= 4);
    if (bx_strobe) begin
      clusters = bx[cyc / 2];
      overflow = (cyc == 4);
      bxn_low  = bxn[cyc / 2];
    end else begin
      overflow = 1'b0;
    end
    @(negedge clk_80);
  end
endtask

`endif

//--- tb/trigger_links_tb.sv
`default_nettype none

`include "trigger_link_defines.svh"

module trigger_links_tb;

  localparam int START_TIMEOUT = 12;                       // Cycles from strobe to frame
  localparam int READY_TIMEOUT = 4 * `TRG_STARTUP_CYCLES;

  localparam trigger_link_pkg::link_word_t IDLE_WORD = '{
    data: {`TRG_K28_5, `TRG_D16_2, `TRG_K28_5, `TRG_D16_2},
    is_k: 4'b1010
  };

  logic                                              clk_80;
  logic                                              reset;
  logic                                              bx_strobe;
  trigger_link_pkg::cluster_bx_t                     clusters;
  logic                                              ttc_bx0;
  logic                                              overflow;
  logic [6:0]                                        bxn_low;
  logic [`TRG_NUM_CLUSTERS-1:0]                      valid_clusters;
  logic                                              valid_clusters_or;
  logic                                              link_ready;
  trigger_link_pkg::link_word_t [`TRG_NUM_LINKS-1:0] tx_words;
  logic                                              tx_frame_start;
  integer                                            seed;

  initial clk_80 = 1'b0;
  always #20 clk_80 = ~clk_80;                             // 40-unit period

  trigger_links u_dut (
    .clk_80            (clk_80),
    .reset             (reset),
    .bx_strobe         (bx_strobe),
    .clusters          (clusters),
    .ttc_bx0           (ttc_bx0),
    .overflow          (overflow),
    .bxn_low           (bxn_low),
    .valid_clusters    (valid_clusters),
    .valid_clusters_or (valid_clusters_or),
    .link_ready        (link_ready),
    .tx_words          (tx_words),
    .tx_frame_start    (tx_frame_start)
  );

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input trigger_link_pkg::link_word_t exp,
                            input trigger_link_pkg::link_word_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mask(input string name, input logic [`TRG_NUM_CLUSTERS-1:0] exp,
                            input logic [`TRG_NUM_CLUSTERS-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------
  // Expected values
  // ------------------------------------------------------------
  function automatic logic [7:0] marker_for(input logic bx0, input logic ovf,
                                            input logic [6:0] bxn);
    if (bx0) return `TRG_K28_0;
    if (ovf) return `TRG_K23_7;
    if (bxn == 7'd0) return `TRG_K28_7;                    // Every 128th BX
    return `TRG_K28_5;
  endfunction

  function automatic logic [`TRG_NUM_CLUSTERS-1:0] mask_for(
    input trigger_link_pkg::cluster_bx_t c);
    logic [`TRG_NUM_CLUSTERS-1:0] m;
    for (int i = 0; i < `TRG_NUM_CLUSTERS; i++) begin
      m[i] = !(c[i].addr[10] && c[i].addr[9]);
    end
    return m;
  endfunction

  function automatic logic [55:0] half_payload(input trigger_link_pkg::cluster_bx_t c,
                                               input logic left);
    return left ? c[7:4] : c[3:0];
  endfunction

  // Phase 0 is the marker word, 1 the payload tail, anything else idle
  function automatic trigger_link_pkg::link_word_t link_word(
    input logic [7:0] marker, input logic [55:0] payload, input int phase);
    trigger_link_pkg::link_word_t w;
    w = IDLE_WORD;
    if (phase == 0) w = '{data: {marker, payload[55:32]}, is_k: 4'b1000};
    if (phase == 1) w = '{data: payload[31:0], is_k: 4'b0000};
    return w;
  endfunction

  function automatic trigger_link_pkg::cluster_bx_t random_bx();
    trigger_link_pkg::cluster_bx_t c;
    for (int i = 0; i < `TRG_NUM_CLUSTERS; i++) begin
      c[i] = 14'($random(seed));
      if (($random(seed) & 3) == 0) c[i].addr[10:9] = 2'b11;   // Empty slot
    end
    return c;
  endfunction

  // Links 2 and 3 repeat 0 and 1 only when mirrored
  task automatic check_links(input string name, input trigger_link_pkg::link_word_t exp_r,
                             input trigger_link_pkg::link_word_t exp_l);
    trigger_link_pkg::link_word_t exp;
    for (int i = 0; i < `TRG_NUM_LINKS; i++) begin
      if (i < 2 || `TRG_MIRROR_LINKS) exp = (i % 2 == 0) ? exp_r : exp_l;
      else exp = IDLE_WORD;
      check_word($sformatf("%s link%0d", name, i), exp, tx_words[i]);
    end
  endtask

  // One-cycle strobe, called and returning on a falling edge
  task automatic send_bx(input trigger_link_pkg::cluster_bx_t c, input logic bx0,
                         input logic ovf, input logic [6:0] bxn);
    bx_strobe = 1'b1;
    clusters  = c;
    ttc_bx0   = bx0;
    overflow  = ovf;
    bxn_low   = bxn;
    @(negedge clk_80);
    bx_strobe = 1'b0;
    ttc_bx0   = 1'b0;
    overflow  = 1'b0;
  endtask

`include "trigger_links_tests.svh"

  initial begin
    seed      = 32'heca3db64;
    reset     = 1'b1;
    bx_strobe = 1'b0;
    clusters  = '0;
    ttc_bx0   = 1'b0;
    overflow  = 1'b0;
    bxn_low   = 7'd1;
    repeat (10) @(negedge clk_80);
    reset = 1'b0;
    test_startup();
    test_valid_mask();
    test_frames();
    test_marker_priority();
    test_back_to_back();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/trigger_links.sv
`default_nettype none

`include "trigger_link_defines.svh"

module trigger_links (
  input  wire logic                                       clk_80,
  input  wire logic                                       reset,
  input  wire logic                                       bx_strobe,
  input  wire trigger_link_pkg::cluster_bx_t              clusters,
  input  wire logic                                       ttc_bx0,
  input  wire logic                                       overflow,
  input  wire logic [6:0]                                 bxn_low,
  output logic [`TRG_NUM_CLUSTERS-1:0]                    valid_clusters,
  output logic                                            valid_clusters_or,
  output logic                                            link_ready,
  output trigger_link_pkg::link_word_t [`TRG_NUM_LINKS-1:0] tx_words,
  output logic                                            tx_frame_start
);

  // ------------------------------------------------------------
  // Stage signals
  // ------------------------------------------------------------
  trigger_link_pkg::cluster_bx_t clusters_q;
  logic                          capture_valid;
  logic                          bx0_q;
  logic                          overflow_q;
  logic [6:0]                    bxn_low_q;
  trigger_link_pkg::link_frame_t frame_r;
  trigger_link_pkg::link_frame_t frame_l;
  logic                          frame_valid;

  cluster_capture u_capture (
    .clk_80            (clk_80),
    .reset             (reset),
    .bx_strobe         (bx_strobe),
    .clusters          (clusters),
    .ttc_bx0           (ttc_bx0),
    .overflow          (overflow),
    .bxn_low           (bxn_low),
    .clusters_q        (clusters_q),
    .capture_valid     (capture_valid),     // T+1
    .bx0_q             (bx0_q),
    .overflow_q        (overflow_q),
    .bxn_low_q         (bxn_low_q),
    .valid_clusters    (valid_clusters),
    .valid_clusters_or (valid_clusters_or)
  );

  link_startup u_startup (
    .clk_80     (clk_80),
    .reset      (reset),
    .link_ready (link_ready)
  );

  link_framer u_framer (
    .clk_80        (clk_80),
    .reset         (reset),
    .clusters_q    (clusters_q),
    .capture_valid (capture_valid),
    .bx0_q         (bx0_q),
    .overflow_q    (overflow_q),
    .bxn_low_q     (bxn_low_q),
    .frame_r       (frame_r),
    .frame_l       (frame_l),
    .frame_valid   (frame_valid)           // T+2
  );

  link_serializer u_serializer (
    .clk_80         (clk_80),
    .reset          (reset),
    .frame_r        (frame_r),
    .frame_l        (frame_l),
    .frame_valid    (frame_valid),
    .link_ready     (link_ready),
    .tx_words       (tx_words),
    .tx_frame_start (tx_frame_start)       // T+3
  );

endmodule

`default_nettype wire

//--- hdl/link_serializer.sv
`default_nettype none

`include "trigger_link_defines.svh"

module link_serializer (
  input  wire logic                                       clk_80,
  input  wire logic                                       reset,
  input  wire trigger_link_pkg::link_frame_t              frame_r,
  input  wire trigger_link_pkg::link_frame_t              frame_l,
  input  wire logic                                       frame_valid,
  input  wire logic                                       link_ready,
  output trigger_link_pkg::link_word_t [`TRG_NUM_LINKS-1:0] tx_words,
  output logic                                            tx_frame_start
);

  localparam trigger_link_pkg::link_word_t IDLE_WORD = '{
    data: {`TRG_K28_5, `TRG_D16_2, `TRG_K28_5, `TRG_D16_2},
    is_k: 4'b1010
  };

  trigger_link_pkg::ser_state_e  ser_state;
  trigger_link_pkg::ser_state_e  ser_state_next;
  trigger_link_pkg::link_frame_t hold_r;
  trigger_link_pkg::link_frame_t hold_l;
  trigger_link_pkg::link_word_t  word_r;
  trigger_link_pkg::link_word_t  word_l;
  logic                          accept;

  // Half of a frame as one transceiver word
  function automatic trigger_link_pkg::link_word_t frame_word(
    input trigger_link_pkg::link_frame_t frame,
    input logic                          low_half
  );
    trigger_link_pkg::link_word_t word;
    if (low_half) begin
      word.data = frame.payload[31:0];
      word.is_k = 4'b0000;
    end else begin
      word.data = {frame.marker, frame.payload[55:32]};
      word.is_k = 4'b1000;                         // Marker byte only
    end
    return word;
  endfunction

  // ------------------------------------------------------------
  // Word phase FSM
  // ------------------------------------------------------------
  assign accept = frame_valid && link_ready;       // Dropped during startup

  always_comb begin
    case (ser_state)
      trigger_link_pkg::ser_high: ser_state_next = trigger_link_pkg::ser_low;
      trigger_link_pkg::ser_low,
      trigger_link_pkg::ser_idle: begin
        ser_state_next = accept ? trigger_link_pkg::ser_high : trigger_link_pkg::ser_idle;
      end
      default: ser_state_next = trigger_link_pkg::ser_idle;
    endcase
  end

  always_ff @(posedge clk_80) begin
    if (reset) begin
      ser_state <= trigger_link_pkg::ser_idle;
    end else begin
      ser_state <= ser_state_next;
    end
  end

  always_ff @(posedge clk_80) begin
    if (accept) begin
      hold_r <= frame_r;
      hold_l <= frame_l;
    end
  end

  always_comb begin
    case (ser_state)
      trigger_link_pkg::ser_high: begin
        word_r = frame_word(hold_r, 1'b0);
        word_l = frame_word(hold_l, 1'b0);
      end
      trigger_link_pkg::ser_low: begin
        word_r = frame_word(hold_r, 1'b1);
        word_l = frame_word(hold_l, 1'b1);
      end
      default: begin
        word_r = IDLE_WORD;
        word_l = IDLE_WORD;
      end
    endcase
  end

  assign tx_frame_start = (ser_state == trigger_link_pkg::ser_high);

  // Even links carry the right frame, odd links the left
  for (genvar i = 0; i < `TRG_NUM_LINKS; i++) begin : g_link
    if (i < 2 || `TRG_MIRROR_LINKS) begin : g_data
      assign tx_words[i] = (i % 2 == 0) ? word_r : word_l;
    end else begin : g_fill
      assign tx_words[i] = IDLE_WORD;
    end
  end

  // A frame must open with its marker character on both primary links
  a_start_is_k: assert property (
    @(posedge clk_80) disable iff (reset)
    tx_frame_start |-> (tx_words[0].is_k == 4'b1000) && (tx_words[1].is_k == 4'b1000)
  ) else $error("frame start without marker K flag");

endmodule

`default_nettype wire

//--- hdl/link_framer.sv
`default_nettype none

`include "trigger_link_defines.svh"

module link_framer (
  input  wire logic                          clk_80,
  input  wire logic                          reset,
  input  wire trigger_link_pkg::cluster_bx_t clusters_q,
  input  wire logic                          capture_valid,
  input  wire logic                          bx0_q,
  input  wire logic                          overflow_q,
  input  wire logic [6:0]                    bxn_low_q,
  output trigger_link_pkg::link_frame_t      frame_r,
  output trigger_link_pkg::link_frame_t      frame_l,
  output logic                               frame_valid
);

  localparam int HALF = `TRG_NUM_CLUSTERS / 2;

  trigger_link_pkg::link_marker_e marker_next;

  // ------------------------------------------------------------
  // Marker priority
  // ------------------------------------------------------------
  always_comb begin
    if (bx0_q) begin
      marker_next = trigger_link_pkg::marker_bc0;      // Orbit start
    end else if (overflow_q) begin
      marker_next = trigger_link_pkg::marker_ovf;      // Clusters were dropped
    end else if (bxn_low_q == 7'd0) begin
      marker_next = trigger_link_pkg::marker_lat;      // Every 128 BX
    end else begin
      marker_next = trigger_link_pkg::marker_idle;
    end
  end

  always_ff @(posedge clk_80) begin
    if (reset) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= capture_valid;
    end
  end

  // Right link gets clusters 0-3 and left link gets 4-7
  always_ff @(posedge clk_80) begin
    if (capture_valid) begin
      frame_r.marker  <= marker_next;
      frame_r.payload <= clusters_q[HALF-1:0];
      frame_l.marker  <= marker_next;
      frame_l.payload <= clusters_q[`TRG_NUM_CLUSTERS-1:HALF];
    end
  end

  // Fixed one-cycle framing stage keeps total latency at three
  a_frame_latency: assert property (
    @(posedge clk_80) disable iff (reset)
    capture_valid |=> frame_valid
  ) else $error("frame_valid missing after capture_valid");

  a_frame_source: assert property (
    @(posedge clk_80) disable iff (reset)
    frame_valid |-> $past(capture_valid)
  ) else $error("frame_valid without capture_valid");

endmodule

`default_nettype wire

//--- hdl/link_startup.sv
`default_nettype none

`include "trigger_link_defines.svh"

module link_startup (
  input  wire logic clk_80,
  input  wire logic reset,
  output logic      link_ready
);

  localparam int CNT_W = $clog2(`TRG_STARTUP_CYCLES + 1);

  logic [CNT_W-1:0] startup_cnt;

  // Saturating count of cycles since reset
  always_ff @(posedge clk_80) begin
    if (reset) begin
      startup_cnt <= '0;
    end else if (!link_ready) begin
      startup_cnt <= startup_cnt + 1'b1;
    end
  end

  assign link_ready = (startup_cnt == CNT_W'(`TRG_STARTUP_CYCLES));  // Stays up once reached

  // Only reset may take the links back to idle
  a_ready_sticky: assert property (
    @(posedge clk_80) link_ready && !reset |=> link_ready
  ) else $error("link_ready fell without reset");

endmodule

`default_nettype wire

//--- hdl/cluster_capture.sv
`default_nettype none

`include "trigger_link_defines.svh"

module cluster_capture (
  input  wire logic                         clk_80,
  input  wire logic                         reset,
  input  wire logic                         bx_strobe,
  input  wire trigger_link_pkg::cluster_bx_t clusters,
  input  wire logic                         ttc_bx0,
  input  wire logic                         overflow,
  input  wire logic [6:0]                   bxn_low,
  output trigger_link_pkg::cluster_bx_t     clusters_q,
  output logic                              capture_valid,
  output logic                              bx0_q,
  output logic                              overflow_q,
  output logic [6:0]                        bxn_low_q,
  output logic [`TRG_NUM_CLUSTERS-1:0]      valid_clusters,
  output logic                              valid_clusters_or
);

  logic [`TRG_NUM_CLUSTERS-1:0] valid_next;

  // Address 11x in bits 10..9 marks an empty slot
  always_comb begin
    for (int i = 0; i < `TRG_NUM_CLUSTERS; i++) begin
      valid_next[i] = (clusters[i].addr[10:9] != 2'b11);
    end
  end

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clk_80) begin
    if (reset) begin
      capture_valid     <= 1'b0;
      valid_clusters    <= '0;
      valid_clusters_or <= 1'b0;
    end else begin
      capture_valid <= bx_strobe;           // One-cycle pulse
      if (bx_strobe) begin
        valid_clusters    <= valid_next;    // Held until next strobe
        valid_clusters_or <= |valid_next;
      end
    end
  end

  // BX payload
  always_ff @(posedge clk_80) begin
    if (bx_strobe) begin
      clusters_q <= clusters;
      bx0_q      <= ttc_bx0;
      overflow_q <= overflow;
      bxn_low_q  <= bxn_low;
    end
  end

  // Downstream frames take two cycles each on the link
  a_strobe_spacing: assert property (
    @(posedge clk_80) disable iff (reset) bx_strobe |=> !bx_strobe
  ) else $error("bx_strobe in adjacent cycles");

endmodule

`default_nettype wire

//--- hdl/trigger_link_pkg.sv
`default_nettype none

`include "trigger_link_defines.svh"

package trigger_link_pkg;

  // One strip cluster
  typedef struct packed {
    logic [2:0]  size;          // Cluster width
    logic [10:0] addr;          // Strip address
  } cluster_t;

  // All clusters of one BX, cluster 0 in the low bits
  typedef cluster_t [`TRG_NUM_CLUSTERS-1:0] cluster_bx_t;

  // Frame marker characters
  typedef enum logic [7:0] {
    marker_idle = `TRG_K28_5,
    marker_bc0  = `TRG_K28_0,
    marker_ovf  = `TRG_K23_7,
    marker_lat  = `TRG_K28_7
  } link_marker_e;

  // 64-bit link frame
  typedef struct packed {
    link_marker_e marker;       // Leading K character
    logic [55:0]  payload;      // Four clusters
  } link_frame_t;

  // Transceiver parallel word
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  is_k;          // One flag per byte, top byte first
  } link_word_t;

  // Serializer word phase
  typedef enum logic [1:0] {
    ser_idle,
    ser_high,
    ser_low
  } ser_state_e;

endpackage

`default_nettype wire

//--- hdl/trigger_link_defines.svh
`ifndef TRIGGER_LINK_DEFINES_SVH
`define TRIGGER_LINK_DEFINES_SVH

// ------------------------------------------------------------
// Link geometry
// ------------------------------------------------------------
`define TRG_NUM_CLUSTERS   8    // Clusters per BX
`define TRG_NUM_LINKS      4    // Output links
`define TRG_STARTUP_CYCLES 16   // Idle cycles after reset
`define TRG_MIRROR_LINKS   1    // Links 2 and 3 repeat links 0 and 1

// ------------------------------------------------------------
// 8b10b character codes
// ------------------------------------------------------------
`define TRG_K28_5 8'hBC         // Comma, idle marker
`define TRG_K28_0 8'h1C         // BC0 marker
`define TRG_K23_7 8'hF7         // Overflow marker
`define TRG_K28_7 8'hFC         // 128-BX latency marker
`define TRG_D16_2 8'h50         // Idle filler data

`endif
